// ==== design/mxu_macros.svh ====
`ifndef MXU_MACROS_SVH
`define MXU_MACROS_SVH

// array shape
`define MXU_ROWS 3  // output lanes, one accumulator each
`define MXU_COLS 3  // input lanes

// operand and sum widths
`define MXU_DATA_W 8
`define MXU_ACC_W 20  // three full 16 bit products fit without wrap
`define MXU_ROW_IDX_W $clog2(`MXU_ROWS)

// result buffering
`define MXU_FIFO_DEPTH 4

`endif

// ==== design/mxu_pkg.sv ====
`include "mxu_macros.svh"

package mxu_pkg;

   ////////////////////////////////////////////////
   // command opcodes
   ////////////////////////////////////////////////

   typedef enum logic {
      OP_LOAD_ROW = 1'b0,  // write one weight row
      OP_COMPUTE  = 1'b1   // push one x vector through the array
   } mxu_op_e;

   ////////////////////////////////////////////////
   // datapath types
   ////////////////////////////////////////////////

   // weights and input lanes
   typedef logic signed [`MXU_DATA_W-1:0] data_t;

   // partial and final row sums
   typedef logic signed [`MXU_ACC_W-1:0] acc_t;

endpackage

// ==== design/mxu_if.sv ====
`timescale 1ns/1ps
`include "mxu_macros.svh"

// feeder to array, weight writes and skewed lanes
interface mxu_feed_if;
   import mxu_pkg::*;

   logic                           load_en;     // one cycle weight write
   logic [`MXU_ROW_IDX_W-1:0]      load_row;
   data_t [`MXU_COLS-1:0]          load_w;      // lane j is w[row][j]
   logic [`MXU_COLS-1:0]           lane_valid;
   data_t [`MXU_COLS-1:0]          lane_x;      // lane j lags lane 0 by j cycles

   modport feeder (
      output load_en,
      output load_row,
      output load_w,
      output lane_valid,
      output lane_x
   );

   modport core (
      input load_en,
      input load_row,
      input load_w,
      input lane_valid,
      input lane_x
   );
endinterface

// array to drain, row sums out of the last column
interface mxu_sum_if;
   import mxu_pkg::*;

   logic [`MXU_ROWS-1:0]  row_valid;
   acc_t [`MXU_ROWS-1:0]  row_sum;
   logic                  room;       // drain can take one more vector

   modport core (
      output row_valid,
      output row_sum
   );

   modport drain (
      input  row_valid,
      input  row_sum,
      output room
   );
endinterface

// ==== design/mxu_mac.sv ====
`timescale 1ns/1ps

module mxu_mac (
   input  logic           clk,
   input  logic           rst,
   input  logic           load_en,
   input  mxu_pkg::data_t load_w,
   input  logic           x_valid,
   input  mxu_pkg::data_t x_in,
   input  mxu_pkg::acc_t  psum_in,
   output logic           x_valid_out,
   output mxu_pkg::data_t x_out,
   output mxu_pkg::acc_t  psum_out
);
   import mxu_pkg::*;

   data_t weight;   // stationary
   acc_t  product;

   // full signed product, sign extended to the sum width
   assign product = acc_t'(weight) * acc_t'(x_in);

   // weight and lane valid
   always_ff @(posedge clk) begin
      if (rst) begin
         weight      <= '0;
         x_valid_out <= 1'b0;
      end else begin
         if (load_en)
            weight <= load_w;
         x_valid_out <= x_valid;  // toward the next row
      end
   end

   // payload only moves with a live lane, holds otherwise
   always_ff @(posedge clk) begin
      if (x_valid) begin
         x_out    <= x_in;               // down
         psum_out <= psum_in + product;  // across
      end
   end

endmodule

// ==== design/mxu_core.sv ====
`timescale 1ns/1ps
`include "mxu_macros.svh"

module mxu_core (
   input logic      clk,
   input logic      rst,
   mxu_feed_if.core feed,
   mxu_sum_if.core  sum
);
   import mxu_pkg::*;

   // lanes passed down, one per cell
   data_t x_dn [`MXU_ROWS][`MXU_COLS];
   logic  v_dn [`MXU_ROWS][`MXU_COLS];

   // partial sums, column 0 entry is the zero seed
   acc_t  psum [`MXU_ROWS][`MXU_COLS+1];

   //////////////////////////////////////////////////
   // cell grid
   //////////////////////////////////////////////////

   for (genvar i = 0; i < `MXU_ROWS; i++) begin : g_row
      localparam logic [`MXU_ROW_IDX_W-1:0] ROW_ID = i;

      logic row_load;

      // only the addressed row takes the weights
      assign row_load  = feed.load_en && (feed.load_row == ROW_ID);
      assign psum[i][0] = '0;

      for (genvar j = 0; j < `MXU_COLS; j++) begin : g_col
         data_t x_src;
         logic  v_src;

         if (i == 0) begin : g_top
            assign x_src = feed.lane_x[j];      // straight from the feeder
            assign v_src = feed.lane_valid[j];
         end else begin : g_below
            assign x_src = x_dn[i-1][j];        // from the row above
            assign v_src = v_dn[i-1][j];
         end

         mxu_mac u_mac (
            .clk         (clk),
            .rst         (rst),
            .load_en     (row_load),
            .load_w      (feed.load_w[j]),
            .x_valid     (v_src),
            .x_in        (x_src),
            .psum_in     (psum[i][j]),
            .x_valid_out (v_dn[i][j]),
            .x_out       (x_dn[i][j]),
            .psum_out    (psum[i][j+1])
         );
      end

      // last column valid marks a finished row sum
      assign sum.row_valid[i] = v_dn[i][`MXU_COLS-1];
      assign sum.row_sum[i]   = psum[i][`MXU_COLS];
   end

endmodule

// ==== design/mxu_feeder.sv ====
`timescale 1ns/1ps
`include "mxu_macros.svh"

module mxu_feeder (
   input  logic                            clk,
   input  logic                            rst,
   input  logic                            cmd_valid,
   output logic                            cmd_ready,
   input  mxu_pkg::mxu_op_e                cmd_op,
   input  logic [`MXU_ROW_IDX_W-1:0]       cmd_row,
   input  logic [`MXU_COLS*`MXU_DATA_W-1:0] cmd_data,
   mxu_feed_if.feeder                      feed,
   input  logic                            room
);
   import mxu_pkg::*;

   localparam int TRACK = `MXU_ROWS + `MXU_COLS;  // cycles a vector spends in the array
   localparam int FRONT = `MXU_COLS + 1;          // until row 0 reaches the drain

   data_t [`MXU_COLS-1:0] cmd_lane;
   logic [TRACK-1:0]      marks;      // one bit per accepted compute, shifts each cycle
   logic                  in_array;
   logic                  front_busy;
   logic                  take;
   logic                  take_load;
   logic                  take_comp;

   assign cmd_lane   = cmd_data;
   assign in_array   = |marks;
   assign front_busy = |marks[FRONT-1:0];  // not yet counted by the drain

   // loads wait for an empty array so no vector sees mixed weights
   always_comb begin
      if (cmd_op == OP_COMPUTE)
         cmd_ready = room && !front_busy;
      else
         cmd_ready = !in_array;
   end

   assign take      = cmd_valid && cmd_ready;
   assign take_load = take && (cmd_op == OP_LOAD_ROW);
   assign take_comp = take && (cmd_op == OP_COMPUTE);

   //////////////////////////////////////////////////
   // weight row load
   //////////////////////////////////////////////////

   always_ff @(posedge clk) begin
      if (rst) begin
         feed.load_en <= 1'b0;
         marks        <= '0;
      end else begin
         feed.load_en <= take_load;
         marks        <= {marks[TRACK-2:0], take_comp};
      end
   end

   always_ff @(posedge clk) begin
      if (take_load) begin
         feed.load_row <= cmd_row;
         feed.load_w   <= cmd_lane;
      end
   end

   //////////////////////////////////////////////////
   // lane skew, lane j goes through j+1 stages
   //////////////////////////////////////////////////

   for (genvar j = 0; j < `MXU_COLS; j++) begin : g_lane
      logic  v_pipe [j+1];
      data_t x_pipe [j+1];

      always_ff @(posedge clk) begin
         if (rst) begin
            for (int k = 0; k <= j; k++)
               v_pipe[k] <= 1'b0;
         end else begin
            v_pipe[0] <= take_comp;
            for (int k = 1; k <= j; k++)
               v_pipe[k] <= v_pipe[k-1];
         end
      end

      always_ff @(posedge clk) begin
         if (take_comp)
            x_pipe[0] <= cmd_lane[j];
         for (int k = 1; k <= j; k++)
            x_pipe[k] <= x_pipe[k-1];
      end

      assign feed.lane_valid[j] = v_pipe[j];
      assign feed.lane_x[j]     = x_pipe[j];
   end

endmodule

// ==== design/mxu_drain.sv ====
`timescale 1ns/1ps
`include "mxu_macros.svh"

module mxu_drain (
   input  logic                            clk,
   input  logic                            rst,
   mxu_sum_if.drain                        sum,
   output logic                            res_valid,
   input  logic                            res_ready,
   output logic [`MXU_ROWS*`MXU_ACC_W-1:0] res_data
);
   import mxu_pkg::*;

   localparam int PTR_W = $clog2(`MXU_FIFO_DEPTH);
   localparam int CNT_W = $clog2(`MXU_FIFO_DEPTH + `MXU_ROWS + 1);
   localparam logic [PTR_W-1:0] PTR_LAST = PTR_W'(`MXU_FIFO_DEPTH - 1);
   localparam logic [CNT_W-1:0] CNT_FULL = CNT_W'(`MXU_FIFO_DEPTH);

   logic [`MXU_ROWS-1:0] al_valid;   // rows lined up on one cycle
   acc_t [`MXU_ROWS-1:0] al_sum;
   acc_t [`MXU_ROWS-1:0] fifo_mem [`MXU_FIFO_DEPTH];
   logic [PTR_W-1:0]     wr_ptr;
   logic [PTR_W-1:0]     rd_ptr;
   logic [CNT_W-1:0]     occ;        // fifo entries
   logic [CNT_W-1:0]     pend;       // vectors between row 0 and push
   logic                 push;
   logic                 pop;

   //////////////////////////////////////////////////
   // deskew, row i waits MXU_ROWS-1-i cycles
   //////////////////////////////////////////////////

   for (genvar i = 0; i < `MXU_ROWS; i++) begin : g_deskew
      localparam int DLY = `MXU_ROWS - 1 - i;

      if (DLY == 0) begin : g_direct
         assign al_valid[i] = sum.row_valid[i];  // last row arrives aligned
         assign al_sum[i]   = sum.row_sum[i];
      end else begin : g_delay
         logic dv [DLY];
         acc_t ds [DLY];

         always_ff @(posedge clk) begin
            if (rst) begin
               for (int k = 0; k < DLY; k++)
                  dv[k] <= 1'b0;
            end else begin
               dv[0] <= sum.row_valid[i];
               for (int k = 1; k < DLY; k++)
                  dv[k] <= dv[k-1];
            end
         end

         always_ff @(posedge clk) begin
            ds[0] <= sum.row_sum[i];
            for (int k = 1; k < DLY; k++)
               ds[k] <= ds[k-1];
         end

         assign al_valid[i] = dv[DLY-1];
         assign al_sum[i]   = ds[DLY-1];
      end
   end

   //////////////////////////////////////////////////
   // result fifo
   //////////////////////////////////////////////////

   assign push      = &al_valid;
   assign pop       = res_valid && res_ready;
   assign res_valid = (occ != '0);
   assign res_data  = fifo_mem[rd_ptr];      // head, row 0 in the low bits
   assign sum.room  = (occ + pend) < CNT_FULL;

   always_ff @(posedge clk) begin
      if (push)
         fifo_mem[wr_ptr] <= al_sum;
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         occ    <= '0;
         pend   <= '0;
      end else begin
         if (push)
            wr_ptr <= (wr_ptr == PTR_LAST) ? '0 : wr_ptr + 1'b1;
         if (pop)
            rd_ptr <= (rd_ptr == PTR_LAST) ? '0 : rd_ptr + 1'b1;
         case ({push, pop})
            2'b10:   occ <= occ + 1'b1;
            2'b01:   occ <= occ - 1'b1;
            default: occ <= occ;
         endcase
         case ({sum.row_valid[0], push})  // first row seen, aligned vector stored
            2'b10:   pend <= pend + 1'b1;
            2'b01:   pend <= pend - 1'b1;
            default: pend <= pend;
         endcase
      end
   end

endmodule

// ==== design/mxu_top.sv ====
`timescale 1ns/1ps
`include "mxu_macros.svh"

module mxu_top (
   input  logic                             clk,
   input  logic                             rst,

   // command stream
   input  logic                             cmd_valid,
   output logic                             cmd_ready,
   input  mxu_pkg::mxu_op_e                 cmd_op,
   input  logic [`MXU_ROW_IDX_W-1:0]        cmd_row,
   input  logic [`MXU_COLS*`MXU_DATA_W-1:0] cmd_data,   // lane j at bits j*8

   // result stream
   output logic                             res_valid,
   input  logic                             res_ready,
   output logic [`MXU_ROWS*`MXU_ACC_W-1:0]  res_data    // row 0 in the low bits
);

   mxu_feed_if feed_bus ();
   mxu_sum_if  sum_bus ();

   //////////////////////////////////////////////////
   // producer, array, consumer
   //////////////////////////////////////////////////

   mxu_feeder i_feeder (
      .clk       (clk),
      .rst       (rst),
      .cmd_valid (cmd_valid),
      .cmd_ready (cmd_ready),
      .cmd_op    (cmd_op),
      .cmd_row   (cmd_row),
      .cmd_data  (cmd_data),
      .feed      (feed_bus.feeder),
      .room      (sum_bus.room)     // credit back from the drain
   );

   mxu_core i_core (
      .clk  (clk),
      .rst  (rst),
      .feed (feed_bus.core),
      .sum  (sum_bus.core)
   );

   mxu_drain i_drain (
      .clk       (clk),
      .rst       (rst),
      .sum       (sum_bus.drain),
      .res_valid (res_valid),
      .res_ready (res_ready),
      .res_data  (res_data)
   );

endmodule

// ==== verification/mxu_clk_gen.sv ====
`timescale 1ns/1ps

module mxu_clk_gen (
   output logic clk,
   output logic rst
);
   localparam int HALF_NS    = 20;  // 40 ns period
   localparam int RST_CYCLES = 10;

   initial begin
      clk = 1'b0;
      forever #HALF_NS clk = ~clk;
   end

   // release on a falling edge, away from the sampling edge
   initial begin
      rst = 1'b1;
      repeat (RST_CYCLES) @(posedge clk);
      @(negedge clk);
      rst = 1'b0;
   end

endmodule

// ==== verification/mxu_sva.sv ====
`timescale 1ns/1ps
`include "mxu_macros.svh"

module mxu_sva (
   input logic                             clk,
   input logic                             rst,
   input logic                             cmd_valid,
   input logic                             cmd_ready,
   input mxu_pkg::mxu_op_e                 cmd_op,
   input logic                             last_row_valid,
   input logic                             res_valid,
   input logic                             res_ready,
   input logic [`MXU_ROWS*`MXU_ACC_W-1:0]  res_data
);
   import mxu_pkg::*;

   localparam int CNT_W = $clog2(`MXU_ROWS + `MXU_COLS + 1) + 1;

   logic             take_comp;
   logic             take_load;
   logic [CNT_W-1:0] in_flight;   // accepted computes whose last row is still in the core
   int               fail_count = 0;

   assign take_comp = cmd_valid && cmd_ready && (cmd_op == OP_COMPUTE);
   assign take_load = cmd_valid && cmd_ready && (cmd_op == OP_LOAD_ROW);

   // a vector leaves the array with the last row sum
   always_ff @(posedge clk) begin
      if (rst)
         in_flight <= '0;
      else
         in_flight <= in_flight + CNT_W'(take_comp) - CNT_W'(last_row_valid);
   end

   //////////////////////////////////////////////////
   // result stream and load ordering
   //////////////////////////////////////////////////

   res_hold: assert property (@(posedge clk) disable iff (rst)
      res_valid && !res_ready |=> res_valid && $stable(res_data))
      else begin
         $error("result dropped or changed while stalled");
         fail_count++;
      end

   res_idle_in_rst: assert property (@(posedge clk) rst |=> !res_valid)
      else begin
         $error("res_valid high during reset");
         fail_count++;
      end

   load_after_drain: assert property (@(posedge clk) disable iff (rst)
      take_load |-> in_flight == '0)
      else begin
         $error("weight load accepted with a vector still in the array");
         fail_count++;
      end

endmodule

bind mxu_top mxu_sva i_sva (
   .clk            (clk),
   .rst            (rst),
   .cmd_valid      (cmd_valid),
   .cmd_ready      (cmd_ready),
   .cmd_op         (cmd_op),
   .last_row_valid (sum_bus.row_valid[`MXU_ROWS-1]),
   .res_valid      (res_valid),
   .res_ready      (res_ready),
   .res_data       (res_data)
);

// ==== verification/mxu_tb.sv ====
`timescale 1ns/1ps
`include "mxu_macros.svh"

module mxu_tb;
   import mxu_pkg::*;

   localparam int TIMEOUT = 200;  // cycles allowed per wait
   localparam int VEC_W   = `MXU_COLS * `MXU_DATA_W;
   localparam int RES_W   = `MXU_ROWS * `MXU_ACC_W;

   logic                      clk;
   logic                      rst;
   logic                      cmd_valid;
   logic                      cmd_ready;
   mxu_op_e                   cmd_op;
   logic [`MXU_ROW_IDX_W-1:0] cmd_row;
   logic [VEC_W-1:0]          cmd_data;
   logic                      res_valid;
   logic                      res_ready;
   logic [RES_W-1:0]          res_data;

   int               w_model [`MXU_ROWS][`MXU_COLS];  // weights as the DUT should hold them
   logic [RES_W-1:0] exp_q [$];
   logic [31:0]      rnd_state  = 32'he80f_663e;
   logic [31:0]      rdy_state  = 32'he80f_663e;
   int               ready_mode = 1;  // 0 stalled, 1 always, 2 random
   int               errors     = 0;
   int               timeouts   = 0;
   int               checks     = 0;

   mxu_clk_gen i_clk_gen (.clk(clk), .rst(rst));

   mxu_top i_mxu_top (
      .clk(clk), .rst(rst),
      .cmd_valid(cmd_valid), .cmd_ready(cmd_ready), .cmd_op(cmd_op),
      .cmd_row(cmd_row), .cmd_data(cmd_data),
      .res_valid(res_valid), .res_ready(res_ready), .res_data(res_data)
   );

   //////////////////////////////////////////////////
   // stimulus helpers
   //////////////////////////////////////////////////

   function automatic logic [31:0] lcg(input logic [31:0] s);
      return s * 32'd1664525 + 32'd1013904223;
   endfunction

   function automatic logic [VEC_W-1:0] rand_vec();
      rnd_state = lcg(rnd_state);
      return rnd_state[31:32-VEC_W];  // upper bits, better spread
   endfunction

   // even lanes get a, odd lanes get b
   function automatic logic [VEC_W-1:0] mix_lanes(input int a, input int b);
      logic [VEC_W-1:0] v;
      for (int j = 0; j < `MXU_COLS; j++)
         v[j*`MXU_DATA_W +: `MXU_DATA_W] = (j % 2 == 0) ? a[`MXU_DATA_W-1:0] : b[`MXU_DATA_W-1:0];
      return v;
   endfunction

   function automatic int lane_val(input logic [VEC_W-1:0] v, input int j);
      return int'($signed(v[j*`MXU_DATA_W +: `MXU_DATA_W]));
   endfunction

   // y[i] = sum over j of w[i][j] * x[j]
   function automatic logic [RES_W-1:0] expect_y(input logic [VEC_W-1:0] x);
      logic [RES_W-1:0] y;
      int               acc;
      for (int i = 0; i < `MXU_ROWS; i++) begin
         acc = 0;
         for (int j = 0; j < `MXU_COLS; j++)
            acc += w_model[i][j] * lane_val(x, j);
         y[i*`MXU_ACC_W +: `MXU_ACC_W] = acc[`MXU_ACC_W-1:0];
      end
      return y;
   endfunction

   // called on a falling edge, returns on the falling edge after the transfer
   task automatic send(input mxu_op_e op, input int row, input logic [VEC_W-1:0] data);
      int waited;
      waited    = 0;
      cmd_valid = 1'b1;
      cmd_op    = op;
      cmd_row   = row[`MXU_ROW_IDX_W-1:0];
      cmd_data  = data;
      @(posedge clk);
      while (!cmd_ready && waited < TIMEOUT) begin
         @(posedge clk);
         waited++;
      end
      if (!cmd_ready) begin
         $display("timeout: command was never accepted");
         timeouts++;
      end
      @(negedge clk);
      cmd_valid = 1'b0;
   endtask

   task automatic wait_drain();
      int waited;
      waited = 0;
      while (exp_q.size() != 0 && waited < TIMEOUT) begin
         @(negedge clk);
         waited++;
      end
      if (exp_q.size() != 0) begin
         $display("timeout: %0d results never came out", exp_q.size());
         timeouts++;
      end
   endtask

   always @(negedge clk) begin
      rdy_state = lcg(rdy_state);
      case (ready_mode)
         0:       res_ready = 1'b0;
         1:       res_ready = 1'b1;
         default: res_ready = rdy_state[20];
      endcase
   end

   //////////////////////////////////////////////////
   // reference model and scoreboard
   //////////////////////////////////////////////////

   always @(posedge clk) begin
      if (!rst) begin
         if (res_valid && res_ready) begin
            assert (exp_q.size() != 0) else begin
               $display("ERROR %0t: result %h with nothing expected", $time, res_data);
               errors++;
            end
            if (exp_q.size() != 0) begin
               checks++;
               assert (res_data == exp_q[0]) else begin
                  $display("ERROR %0t: result %h expected %h", $time, res_data, exp_q[0]);
                  errors++;
               end
               void'(exp_q.pop_front());
            end
         end
         if (cmd_valid && cmd_ready) begin
            if (cmd_op == OP_LOAD_ROW) begin
               for (int j = 0; j < `MXU_COLS; j++)
                  w_model[cmd_row][j] = lane_val(cmd_data, j);
            end else begin
               exp_q.push_back(expect_y(cmd_data));  // old weights for this vector
            end
         end
      end
   end

   //////////////////////////////////////////////////
   // test sequence
   //////////////////////////////////////////////////

   initial begin
      int waited;
      cmd_valid = 1'b0;
      cmd_op    = OP_LOAD_ROW;
      cmd_row   = '0;
      cmd_data  = '0;
      res_ready = 1'b0;
      waited    = 0;
      while (rst !== 1'b0 && waited < TIMEOUT) begin
         @(negedge clk);
         waited++;
      end
      if (rst !== 1'b0) begin
         $display("timeout: reset never released");
         timeouts++;
      end
      @(negedge clk);
      assert (cmd_ready === 1'b1 && res_valid === 1'b0) else begin
         $display("ERROR %0t: wrong state after reset", $time);
         errors++;
      end
      send(OP_COMPUTE, 0, rand_vec());  // zero weights give zero y

      // random matrix and vectors
      for (int i = 0; i < `MXU_ROWS; i++)
         send(OP_LOAD_ROW, i, rand_vec());
      repeat (8) send(OP_COMPUTE, 0, rand_vec());

      // signed extremes
      send(OP_LOAD_ROW, 0, mix_lanes(-128, -128));
      send(OP_LOAD_ROW, 1, mix_lanes(127, 127));
      send(OP_LOAD_ROW, 2, mix_lanes(-128, 127));
      send(OP_COMPUTE, 0, mix_lanes(-128, -128));
      send(OP_COMPUTE, 0, mix_lanes(127, 127));
      send(OP_COMPUTE, 0, mix_lanes(127, -128));
      wait_drain();

      // burst against a stalled result stream
      ready_mode = 0;
      fork
         repeat (6) send(OP_COMPUTE, 0, rand_vec());
         begin
            repeat (60) @(negedge clk);
            assert (!cmd_ready && exp_q.size() == `MXU_FIFO_DEPTH) else begin
               $display("ERROR %0t: no back-pressure, %0d results held", $time, exp_q.size());
               errors++;
            end
            ready_mode = 1;
         end
      join
      wait_drain();

      // reload a row between computes
      send(OP_COMPUTE, 0, rand_vec());
      send(OP_LOAD_ROW, 1, rand_vec());
      send(OP_COMPUTE, 0, rand_vec());

      // random consumer
      ready_mode = 2;
      for (int k = 0; k < 12; k++) begin
         if (k == 5)
            send(OP_LOAD_ROW, 0, rand_vec());
         else
            send(OP_COMPUTE, 0, rand_vec());
      end
      wait_drain();
      repeat (5) @(negedge clk);

      $display("checks %0d, errors %0d, timeouts %0d, assertion failures %0d",
               checks, errors, timeouts, i_mxu_top.i_sva.fail_count);
      if (errors == 0 && timeouts == 0 && checks > 0 && i_mxu_top.i_sva.fail_count == 0)
         $display("TESTS PASSED");
      else
         $display("TESTS FAILED");
      $finish;
   end

endmodule

// ==== all.f ====
+incdir+design
design/mxu_pkg.sv
design/mxu_if.sv
design/mxu_mac.sv
design/mxu_core.sv
design/mxu_feeder.sv
design/mxu_drain.sv
design/mxu_top.sv
verification/mxu_clk_gen.sv
verification/mxu_sva.sv
verification/mxu_tb.sv

// ==== Makefile ====
.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build mxu_tb with Verilator, run it, fail on TESTS FAILED in sim.log"
	@echo "  clean  remove obj_dir and sim.log"

test:
	verilator --binary --timing --assert -Wno-fatal --top-module mxu_tb \
		-f all.f --Mdir obj_dir -o mxu_sim
	./obj_dir/mxu_sim > sim.log 2>&1; status=$$?; cat sim.log; \
	if [ $$status -ne 0 ] || grep -q "TESTS FAILED" sim.log; then \
		echo "simulation failed"; exit 1; \
	fi

clean:
	rm -rf obj_dir sim.log
